// File: hdl/div_settings.svh
`ifndef DIV_SETTINGS_SVH
`define DIV_SETTINGS_SVH

// ----------------------------------------
// Division unit configuration
// ----------------------------------------

// Operand and result width
`define DIV_XLEN 32

// Reservation station entries
// Keep a power of 2, the entry index is log2 of this wide
`define DIV_RS_DEPTH 4

// Register stages behind the combinational divider
// Any value of 1 or more works
`define DIV_PIPE_DEPTH 4

`endif

// File: hdl/div_pkg.sv
`include "div_settings.svh"

package div_pkg;

    // ----------------------------------------
    // Basic types
    // ----------------------------------------

    // RV32M division flavours
    typedef enum logic [1:0] {
        OP_DIV  = 2'b00,
        OP_DIVU = 2'b01,
        OP_REM  = 2'b10,
        OP_REMU = 2'b11
    } div_op_t;

    typedef logic [`DIV_XLEN-1:0] xlen_t;

    // Reservation station entry index
    typedef logic [$clog2(`DIV_RS_DEPTH)-1:0] rs_idx_t;

    // ----------------------------------------
    // Pipeline payloads
    // ----------------------------------------

    // Prepared request, one pipeline slot
    typedef struct packed {
        rs_idx_t entry_idx;
        xlen_t   rs1_mag;    // dividend magnitude
        xlen_t   rs2_mag;    // divisor magnitude
        logic    rem_sel;    // return remainder instead of quotient
        logic    neg_quot;
        logic    neg_rem;
        logic    div_zero;
        logic    ovf;        // most negative / -1
        xlen_t   dividend;   // raw rs1, the remainder on divide by zero
    } div_req_t;

    // Finished result going back to the reservation station
    typedef struct packed {
        rs_idx_t entry_idx;
        xlen_t   result;
    } div_res_t;

endpackage

// File: hdl/spill_cell_flush.sv
`include "div_settings.svh"

module spill_cell_flush
    import div_pkg::*;
#(
    parameter type DATA_T = div_res_t
) (
    input  logic  clk_i,
    input  logic  rst_n_i,
    input  logic  flush_i,

    // Upstream side
    input  logic  valid_i,
    output logic  ready_o,
    input  DATA_T data_i,

    // Downstream side
    output logic  valid_o,
    input  logic  ready_i,
    output DATA_T data_o
);

    // ----------------------------------------
    // Storage
    // ----------------------------------------

    logic  valid_q;
    DATA_T data_q;

    // Room when empty, or when the held item leaves this cycle
    assign ready_o = !valid_q || ready_i;

    // Occupancy flag
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (flush_i) begin
            // Drop whatever is held
            valid_q <= 1'b0;
        end else if (ready_o) begin
            valid_q <= valid_i;
        end
    end

    // Payload, only written on an accepted transfer
    always_ff @(posedge clk_i) begin
        if (ready_o && valid_i) begin
            data_q <= data_i;
        end
    end

    assign valid_o = valid_q;
    assign data_o  = data_q;

    // ----------------------------------------
    // Checks
    // ----------------------------------------

    // A stalled item must be held unchanged for the next cycle
    a_hold_on_stall: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (valid_o && !ready_i && !flush_i) |=> (valid_o && $stable(data_o))
    ) else $error("spill cell changed its output while stalled");

endmodule

// File: hdl/div_operand_prep.sv
`include "div_settings.svh"

module div_operand_prep
    import div_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  logic     flush_i,

    // From the reservation station
    input  logic     valid_i,
    output logic     ready_o,
    input  div_op_t  op_i,
    input  rs_idx_t  entry_idx_i,
    input  xlen_t    rs1_value_i,
    input  xlen_t    rs2_value_i,

    // To the divider pipeline
    output logic     valid_o,
    input  logic     ready_i,
    output div_req_t req_o
);

    // ----------------------------------------
    // Operation decode
    // ----------------------------------------

    logic     is_signed;
    logic     is_rem;
    logic     rs1_neg;
    logic     rs2_neg;
    xlen_t    rs1_mag;
    xlen_t    rs2_mag;
    logic     div_zero;
    logic     ovf;
    div_req_t req_d;

    assign is_signed = (op_i == OP_DIV) || (op_i == OP_REM);
    assign is_rem    = (op_i == OP_REM) || (op_i == OP_REMU);

    // Sign bits only count for the signed flavours
    assign rs1_neg = is_signed && rs1_value_i[`DIV_XLEN-1];
    assign rs2_neg = is_signed && rs2_value_i[`DIV_XLEN-1];

    // Absolute values
    // The most negative value maps onto itself, which is still the right
    // unsigned magnitude
    assign rs1_mag = rs1_neg ? -rs1_value_i : rs1_value_i;
    assign rs2_mag = rs2_neg ? -rs2_value_i : rs2_value_i;

    // ----------------------------------------
    // Special cases
    // ----------------------------------------

    assign div_zero = (rs2_value_i == '0);

    // Signed overflow, most negative dividend over -1
    assign ovf = is_signed
              && (rs1_value_i == {1'b1, {(`DIV_XLEN-1){1'b0}}})
              && (rs2_value_i == '1);

    // Request packing
    always_comb begin
        req_d.entry_idx = entry_idx_i;
        req_d.rs1_mag   = rs1_mag;
        req_d.rs2_mag   = rs2_mag;
        req_d.rem_sel   = is_rem;
        // Quotient negative when operand signs differ
        req_d.neg_quot  = rs1_neg ^ rs2_neg;
        // Remainder follows the dividend
        req_d.neg_rem   = rs1_neg;
        req_d.div_zero  = div_zero;
        req_d.ovf       = ovf;
        req_d.dividend  = rs1_value_i;
    end

    // Registered handoff to the pipeline
    spill_cell_flush #(
        .DATA_T (div_req_t)
    ) u_req_reg (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .flush_i (flush_i),
        .valid_i (valid_i),
        .ready_o (ready_o),
        .data_i  (req_d),
        .valid_o (valid_o),
        .ready_i (ready_i),
        .data_o  (req_o)
    );

endmodule

// File: hdl/div_pipe.sv
`include "div_settings.svh"

module div_pipe
    import div_pkg::*;
#(
    parameter int unsigned PIPE_DEPTH = `DIV_PIPE_DEPTH
) (
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  logic     flush_i,

    // From the operand prep stage
    input  logic     valid_i,
    output logic     ready_o,
    input  div_req_t req_i,

    // To the output cell
    output logic     valid_o,
    input  logic     ready_i,
    output div_res_t res_o
);

    // ----------------------------------------
    // Stage 0, divide and fix up
    // ----------------------------------------

    xlen_t    quot_mag;
    xlen_t    rem_mag;
    xlen_t    quot;
    xlen_t    rem;
    xlen_t    result;
    div_res_t res_d;

    // Unsigned core on magnitudes
    // Zero divisor is kept away from the operators, flags decide later
    assign quot_mag = (req_i.rs2_mag != '0) ? req_i.rs1_mag / req_i.rs2_mag : '1;
    assign rem_mag  = (req_i.rs2_mag != '0) ? req_i.rs1_mag % req_i.rs2_mag : req_i.rs1_mag;

    // Restore signs
    assign quot = req_i.neg_quot ? -quot_mag : quot_mag;
    assign rem  = req_i.neg_rem  ? -rem_mag  : rem_mag;

    always_comb begin
        if (req_i.div_zero) begin
            // x/0 gives all ones, x%0 gives x
            result = req_i.rem_sel ? req_i.dividend : '1;
        end else if (req_i.ovf) begin
            // MIN/-1 gives MIN, remainder zero
            result = req_i.rem_sel ? '0 : {1'b1, {(`DIV_XLEN-1){1'b0}}};
        end else begin
            result = req_i.rem_sel ? rem : quot;
        end
    end

    assign res_d.entry_idx = req_i.entry_idx;
    assign res_d.result    = result;

    // ----------------------------------------
    // Register chain
    // ----------------------------------------

    logic [PIPE_DEPTH-1:0] stage_valid;
    div_res_t              stage_res [PIPE_DEPTH];

    // All stages move together, bubbles stay in place
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            stage_valid <= '0;
            for (int i = 0; i < PIPE_DEPTH; i++) begin
                stage_res[i] <= '0;
            end
        end else if (flush_i) begin
            // Drop everything in flight
            stage_valid <= '0;
            for (int i = 0; i < PIPE_DEPTH; i++) begin
                stage_res[i] <= '0;
            end
        end else if (ready_i) begin
            stage_valid[0] <= valid_i;
            stage_res[0]   <= res_d;
            for (int i = 1; i < PIPE_DEPTH; i++) begin
                stage_valid[i] <= stage_valid[i-1];
                stage_res[i]   <= stage_res[i-1];
            end
        end
    end

    // Stall-together, so ready comes straight from the output cell
    assign ready_o = ready_i;
    assign valid_o = stage_valid[PIPE_DEPTH-1];
    assign res_o   = stage_res[PIPE_DEPTH-1];

    // ----------------------------------------
    // Checks
    // ----------------------------------------

    // Flush empties the whole chain in one edge
    a_flush_clears: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        flush_i |=> (stage_valid == '0)
    ) else $error("pipeline stage still valid after flush");

endmodule

// File: hdl/div_unit.sv
`include "div_settings.svh"

module div_unit
    import div_pkg::*;
(
    input  logic    clk_i,
    input  logic    rst_n_i,
    input  logic    flush_i,

    // Request side, reservation station
    input  logic    valid_i,
    output logic    ready_o,
    input  div_op_t op_i,
    input  rs_idx_t entry_idx_i,
    input  xlen_t   rs1_value_i,
    input  xlen_t   rs2_value_i,

    // Result side
    output logic    valid_o,
    input  logic    ready_i,
    output rs_idx_t entry_idx_o,
    output xlen_t   result_o
);

    // ----------------------------------------
    // Interconnect
    // ----------------------------------------

    logic     prep_valid;
    div_req_t prep_req;
    logic     pipe_ready;
    logic     pipe_valid;
    div_res_t pipe_res;
    logic     out_ready;
    div_res_t out_res;

    // Operand conditioning, one cycle
    div_operand_prep u_prep (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .flush_i     (flush_i),
        .valid_i     (valid_i),
        .ready_o     (ready_o),
        .op_i        (op_i),
        .entry_idx_i (entry_idx_i),
        .rs1_value_i (rs1_value_i),
        .rs2_value_i (rs2_value_i),
        .valid_o     (prep_valid),
        .ready_i     (pipe_ready),
        .req_o       (prep_req)
    );

    // Divider and delay chain
    div_pipe #(
        .PIPE_DEPTH (`DIV_PIPE_DEPTH)
    ) u_pipe (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .flush_i (flush_i),
        .valid_i (prep_valid),
        .ready_o (pipe_ready),
        .req_i   (prep_req),
        .valid_o (pipe_valid),
        .ready_i (out_ready),
        .res_o   (pipe_res)
    );

    // Output register toward the reservation station
    spill_cell_flush #(
        .DATA_T (div_res_t)
    ) u_out_reg (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .flush_i (flush_i),
        .valid_i (pipe_valid),
        .ready_o (out_ready),
        .data_i  (pipe_res),
        .valid_o (valid_o),
        .ready_i (ready_i),
        .data_o  (out_res)
    );

    // Unpack the result
    assign entry_idx_o = out_res.entry_idx;
    assign result_o    = out_res.result;

endmodule

// File: tests/div_ref_model.svh
`ifndef DIV_REF_MODEL_SVH
`define DIV_REF_MODEL_SVH

// ----------------------------------------
// RV32M division reference
// ----------------------------------------

// Expected result of one division op
// Signed quotient truncates toward zero, remainder follows the dividend
function automatic xlen_t ref_div(input div_op_t op, input xlen_t a, input xlen_t b);
    logic signed [`DIV_XLEN-1:0] sa;
    logic signed [`DIV_XLEN-1:0] sb;
    logic                        is_signed_op;
    logic                        want_rem;
    xlen_t                       quot;
    xlen_t                       rem;
    sa = a;
    sb = b;
    is_signed_op = (op == OP_DIV) || (op == OP_REM);
    want_rem     = (op == OP_REM) || (op == OP_REMU);
    if (b == '0) begin
        // Divide by zero, spec gives all ones and the dividend
        quot = '1;
        rem  = a;
    end else if (is_signed_op && (sa == XLEN_MIN) && (sb == -1)) begin
        // Overflow, kept away from the native operator
        quot = XLEN_MIN;
        rem  = '0;
    end else if (is_signed_op) begin
        quot = sa / sb;
        rem  = sa % sb;
    end else begin
        quot = a / b;
        rem  = a % b;
    end
    ref_div = want_rem ? rem : quot;
endfunction

`endif

// File: tests/tb_div_unit.sv
`include "div_settings.svh"

module tb_div_unit
    import div_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    // ----------------------------------------
    // Constants and DUT signals
    // ----------------------------------------

    localparam int    CLK_HALF   = 50;
    localparam int    DRIVE_DLY  = 10;
    localparam int    WAIT_LIMIT = 200;
    // Output transfer edge counted from the accepting edge
    localparam int    LATENCY    = `DIV_PIPE_DEPTH + 2;
    localparam xlen_t XLEN_MIN   = {1'b1, {(`DIV_XLEN-1){1'b0}}};

    logic    clk_i;
    logic    rst_n_i;
    logic    flush_i;
    logic    valid_i;
    logic    ready_o;
    div_op_t op_i;
    rs_idx_t entry_idx_i;
    xlen_t   rs1_value_i;
    xlen_t   rs2_value_i;
    logic    valid_o;
    logic    ready_i;
    rs_idx_t entry_idx_o;
    xlen_t   result_o;

    // One accepted request as the scoreboard sees it
    typedef struct packed {
        div_op_t op;
        rs_idx_t idx;
        xlen_t   res;
        xlen_t   a;
        xlen_t   b;
    } exp_item_t;

    exp_item_t exp_q[$];
    string     test_name;
    integer    seed;
    logic      bp_active;

    `include "div_ref_model.svh"

    div_unit u_dut (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .flush_i     (flush_i),
        .valid_i     (valid_i),
        .ready_o     (ready_o),
        .op_i        (op_i),
        .entry_idx_i (entry_idx_i),
        .rs1_value_i (rs1_value_i),
        .rs2_value_i (rs2_value_i),
        .valid_o     (valid_o),
        .ready_i     (ready_i),
        .entry_idx_o (entry_idx_o),
        .result_o    (result_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #CLK_HALF clk_i = ~clk_i;
    end

    // ----------------------------------------
    // Failure reporting
    // ----------------------------------------

    task automatic abort_run(input string why);
        $display("Error in %s: %s", test_name, why);
        $display("test failed");
        $fatal(1, "run stopped");
    endtask

    task automatic report_mismatch(input string what, input xlen_t exp, input xlen_t act);
        $display("ERR %s: %s expected %0h actual %0h", test_name, what, exp, act);
        $display("test failed");
        $fatal(1, "value mismatch");
    endtask

    // Signed result obeys truncation toward zero
    // Implied remainder is smaller than the divisor and has the dividend's sign or is zero
    function automatic bit signed_rule_ok(input div_op_t op, input xlen_t a, input xlen_t b,
                                          input xlen_t res);
        longint sa;
        longint sb;
        longint sres;
        longint rem;
        bit     ok;
        sa   = longint'($signed(a));
        sb   = longint'($signed(b));
        sres = longint'($signed(res));
        ok   = 1'b1;
        if (op == OP_DIV) begin
            rem = sa - sres * sb;
        end else begin
            rem = sres;
            // Dividend minus remainder must be a whole multiple of the divisor
            if (((sa - rem) % sb) != 0) ok = 1'b0;
        end
        if ((rem < 0 ? -rem : rem) >= (sb < 0 ? -sb : sb)) ok = 1'b0;
        if ((rem != 0) && ((rem < 0) != (sa < 0))) ok = 1'b0;
        return ok;
    endfunction

    // ----------------------------------------
    // Scoreboard and result checker
    // ----------------------------------------

    always @(posedge clk_i) begin : track_requests
        exp_item_t item;
        if (rst_n_i) begin
            if (flush_i) begin
                // Flush drops everything in flight including an offer on this edge
                exp_q.delete();
            end else if (valid_i && ready_o) begin
                item.op  = op_i;
                item.idx = entry_idx_i;
                item.res = ref_div(op_i, rs1_value_i, rs2_value_i);
                item.a   = rs1_value_i;
                item.b   = rs2_value_i;
                exp_q.push_back(item);
            end
        end
    end

    always @(posedge clk_i) begin : check_results
        exp_item_t item;
        if (rst_n_i && !flush_i && valid_o && ready_i) begin
            if (exp_q.size() == 0) begin
                abort_run("valid_o raised with no request outstanding");
            end else begin
                item = exp_q.pop_front();
                assert (entry_idx_o == item.idx)
                    else report_mismatch("entry_idx_o", item.idx, entry_idx_o);
                assert (result_o == item.res)
                    else report_mismatch("result_o", item.res, result_o);
                // Regular signed cases only
                if ((item.op == OP_DIV || item.op == OP_REM) && (item.b != '0)
                        && !((item.a == XLEN_MIN) && (item.b == '1))) begin
                    assert (signed_rule_ok(item.op, item.a, item.b, result_o))
                        else abort_run($sformatf("%0h op %0h gives %0h, not truncated toward zero",
                                                 item.a, item.b, result_o));
                end
            end
        end
    end

    // ----------------------------------------
    // Stimulus helpers
    // ----------------------------------------

    // Holds the offered request until an edge with ready_o high
    task automatic wait_accept(output int waits);
        logic taken;
        taken = 1'b0;
        waits = 0;
        while (!taken) begin
            @(posedge clk_i);
            taken = ready_o;
            if (!taken) begin
                waits++;
                if (waits > WAIT_LIMIT) abort_run("request never accepted, ready_o stuck low");
            end
        end
        #DRIVE_DLY;
    endtask

    task automatic send_req(input div_op_t op, input rs_idx_t idx, input xlen_t a,
                            input xlen_t b, output int waits);
        valid_i     = 1'b1;
        op_i        = op;
        entry_idx_i = idx;
        rs1_value_i = a;
        rs2_value_i = b;
        wait_accept(waits);
        valid_i = 1'b0;
    endtask

    // Returns on the edge where valid_o is first seen
    task automatic wait_valid(output int edges);
        edges = 0;
        do begin
            @(posedge clk_i);
            edges++;
            if (edges > WAIT_LIMIT) abort_run("valid_o never rose");
        end while (!valid_o);
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0) begin
            @(posedge clk_i);
            #DRIVE_DLY;
            cycles++;
            if (cycles > WAIT_LIMIT) abort_run("outstanding results never arrived");
        end
    endtask

    // Random back-pressure that ends with ready_i high
    task automatic toggle_ready();
        logic next_ready;
        @(posedge clk_i);
        while (bp_active) begin
            next_ready = 1'($random(seed));
            #DRIVE_DLY;
            ready_i = next_ready;
            @(posedge clk_i);
        end
        #DRIVE_DLY;
        ready_i = 1'b1;
    endtask

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------

    initial begin : run_tests
        int   i;
        int   waits;
        int   edges;
        logic stalled;
        seed        = 61;
        test_name   = "reset";
        bp_active   = 1'b0;
        rst_n_i     = 1'b0;
        flush_i     = 1'b0;
        valid_i     = 1'b0;
        ready_i     = 1'b1;
        op_i        = OP_DIV;
        entry_idx_i = '0;
        rs1_value_i = '0;
        rs2_value_i = '0;
        repeat (8) @(posedge clk_i);
        #DRIVE_DLY;
        rst_n_i = 1'b1;
        assert (ready_o && !valid_o) else abort_run("unit not idle after reset");

        // Signed ops with the divisor magnitude spread by the shift
        test_name = "signed";
        for (i = 0; i < 32; i++) begin
            send_req(i[0] ? OP_REM : OP_DIV, rs_idx_t'(i), $random(seed),
                     $random(seed) >>> (i % 28), waits);
        end
        wait_drain();

        test_name = "unsigned";
        for (i = 0; i < 32; i++) begin
            send_req(i[0] ? OP_REMU : OP_DIVU, rs_idx_t'(i), $random(seed),
                     xlen_t'($random(seed)) >> (i % 28), waits);
        end
        wait_drain();

        test_name = "special";
        send_req(OP_DIV, 0, 32'h1234_5678, '0, waits);
        send_req(OP_REM, 1, 32'h8765_4321, '0, waits);
        send_req(OP_DIVU, 2, 32'hdead_beef, '0, waits);
        send_req(OP_REMU, 3, 32'h0000_0042, '0, waits);
        send_req(OP_DIV, 0, XLEN_MIN, '1, waits);
        send_req(OP_REM, 1, XLEN_MIN, '1, waits);
        wait_drain();

        test_name = "latency";
        send_req(OP_DIVU, 1, 32'd1000, 32'd7, waits);
        wait_valid(edges);
        assert (edges == LATENCY) else report_mismatch("latency", LATENCY, edges);
        #DRIVE_DLY;
        wait_drain();

        // One per cycle in and one per cycle out
        test_name = "throughput";
        fork
            begin
                for (i = 0; i < 12; i++) begin
                    send_req(OP_DIV, rs_idx_t'(i), $random(seed), $random(seed), waits);
                    assert (waits == 0) else abort_run("back-to-back request not taken");
                end
            end
            begin
                wait_valid(edges);
                repeat (11) begin
                    @(posedge clk_i);
                    assert (valid_o) else abort_run("gap in back-to-back output stream");
                end
            end
        join
        #DRIVE_DLY;
        wait_drain();

        // Fill the stalled unit until ready_o drops
        test_name = "backpressure";
        ready_i   = 1'b0;
        stalled   = 1'b0;
        valid_i   = 1'b1;
        i         = 0;
        while (!stalled) begin
            op_i        = div_op_t'($random(seed));
            entry_idx_i = rs_idx_t'(i);
            rs1_value_i = $random(seed);
            rs2_value_i = $random(seed) >>> 12;
            @(posedge clk_i);
            stalled = !ready_o;
            i++;
            if (i > WAIT_LIMIT) abort_run("ready_o never fell while stalled and full");
            #DRIVE_DLY;
        end
        bp_active = 1'b1;
        fork
            begin
                wait_accept(waits);
                valid_i = 1'b0;
                for (i = 0; i < 24; i++) begin
                    send_req(div_op_t'($random(seed)), rs_idx_t'(i), $random(seed),
                             $random(seed) >>> 8, waits);
                end
                bp_active = 1'b0;
            end
            toggle_ready();
        join
        wait_drain();

        // Drop a few items in flight with a flush pulse
        test_name = "flush";
        ready_i   = 1'b0;
        for (i = 0; i < 3; i++) begin
            send_req(OP_REM, rs_idx_t'(i), $random(seed), 32'd13, waits);
        end
        flush_i = 1'b1;
        @(posedge clk_i);
        #DRIVE_DLY;
        flush_i = 1'b0;
        ready_i = 1'b1;
        for (i = 0; i < 2 * LATENCY; i++) begin
            @(posedge clk_i);
            assert (!valid_o) else abort_run("valid_o raised for a flushed item");
        end
        #DRIVE_DLY;
        send_req(OP_DIV, 3, -32'sd100, 32'sd7, waits);
        wait_drain();

        if (exp_q.size() == 0) begin
            $display("test passed");
            $finish;
        end else begin
            $display("Error: %0d results never arrived", exp_q.size());
            $display("test failed");
            $fatal(1, "outstanding results at end of run");
        end
    end

endmodule

// File: compile.f
+incdir+hdl
+incdir+tests
hdl/div_pkg.sv
hdl/spill_cell_flush.sv
hdl/div_operand_prep.sv
hdl/div_pipe.sv
hdl/div_unit.sv
tests/tb_div_unit.sv
